//--- dv/scratchpad_golden.txt
// op0 addr0 wdata0 strb0 exp0 op1 addr1 wdata1 strb1 exp1, one step per line
// op: 0 none, 1 read, 2 write, f end of steps; exp is the read data expected
1 000 00000000 0 00000000 1 004 00000000 0 00000000
1 008 00000000 0 00000000 1 010 00000000 0 00000000
1 020 00000000 0 00000000 1 100 00000000 0 00000000
1 3fc 00000000 0 00000000 0 000 00000000 0 00000000
2 000 11223344 f 00000000 0 000 00000000 0 00000000
1 000 00000000 0 11223344 0 000 00000000 0 00000000
0 000 00000000 0 00000000 2 004 a5a5a5a5 f 00000000
0 000 00000000 0 00000000 1 004 00000000 0 a5a5a5a5
2 000 deadbeef 3 00000000 0 000 00000000 0 00000000
1 000 00000000 0 1122beef 0 000 00000000 0 00000000
0 000 00000000 0 00000000 2 004 00ff0000 4 00000000
0 000 00000000 0 00000000 1 004 00000000 0 a5ffa5a5
2 010 cafe0000 c 00000000 0 000 00000000 0 00000000
0 000 00000000 0 00000000 1 010 00000000 0 cafe0000
2 020 0badf00d f 00000000 0 000 00000000 0 00000000
0 000 00000000 0 00000000 1 020 00000000 0 0badf00d
0 000 00000000 0 00000000 2 3fc 87654321 f 00000000
1 3fc 00000000 0 87654321 0 000 00000000 0 00000000
2 100 13579bdf f 00000000 2 008 2468ace0 f 00000000
1 008 00000000 0 2468ace0 1 100 00000000 0 13579bdf
1 000 00000000 0 1122beef 1 020 00000000 0 0badf00d
2 004 0000003c 1 00000000 1 010 00000000 0 cafe0000
1 004 00000000 0 a5ffa53c 1 3fc 00000000 0 87654321
2 400 ffffffff f 00000000 0 000 00000000 0 00000000
0 000 00000000 0 00000000 2 ffc 12345678 f 00000000
1 404 00000000 0 00000000 1 800 00000000 0 00000000
1 000 00000000 0 1122beef 1 3fc 00000000 0 87654321
f 000 00000000 0 00000000 f 000 00000000 0 00000000

//--- dv/scratchpad_sva.sv
`timescale 1ns/100ps

module scratchpad_sva #(
	parameter int ADDR_W = scratch_pkg::ADDR_W,
	parameter int DATA_W = scratch_pkg::DATA_W
) (
	input logic clk,
	input logic rst_n,
	input logic psel,
	input logic pready,
	input logic [ADDR_W-1:0] paddr,
	input logic [DATA_W-1:0] pwdata,
	input logic req_a,
	input logic gnt_a,
	input logic req_b,
	input logic gnt_b
);

	// ************************************************************
	// APB side
	// ************************************************************

	// Address and write data held through SETUP and wait states
	apb_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(psel && !pready) |=> ($stable(paddr) && $stable(pwdata)))
		else $error("APB address or write data changed before pready");

	// ************************************************************
	// Grant rules
	// ************************************************************
	gnt_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(gnt_a && gnt_b))
		else $error("Both requesters granted in one cycle");

	// Granted in the request cycle or the one after
	req_a_served: assert property (@(posedge clk) disable iff (!rst_n)
		(req_a && !gnt_a) |=> gnt_a)
		else $error("Request on first requester waited more than two cycles");

	req_b_served: assert property (@(posedge clk) disable iff (!rst_n)
		(req_b && !gnt_b) |=> gnt_b)
		else $error("Request on second requester waited more than two cycles");

endmodule

// Port view, single requester
bind apb_mem_port scratchpad_sva #(.DATA_W(DATA_W)) u_port_sva (
	.clk    (clk),
	.rst_n  (rst_n),
	.psel   (psel),
	.pready (pready),
	.paddr  (paddr),
	.pwdata (pwdata),
	.req_a  (mem.req),
	.gnt_a  (mem.gnt),
	.req_b  (1'b0),
	.gnt_b  (1'b0)
);

// Arbiter view, APB inputs tied off
bind mem_arbiter scratchpad_sva #(.DATA_W(DATA_W)) u_arb_sva (
	.clk    (clk),
	.rst_n  (rst_n),
	.psel   (1'b0),
	.pready (1'b0),
	.paddr  ('0),
	.pwdata ('0),
	.req_a  (m0.req),
	.gnt_a  (m0.gnt),
	.req_b  (m1.req),
	.gnt_b  (m1.gnt)
);

//--- dv/tb_shared_scratchpad.sv
`timescale 1ns/100ps

module tb_shared_scratchpad;
	import scratch_pkg::*;

	// Memory depth in words, handed to the DUT
	localparam int DEPTH = 256;
	localparam int RESET_CYCLES = 10;
	localparam int CYCLES_PER_STEP = 40;

	// Golden file layout, ten fields per step
	localparam int FIELDS = 10;
	localparam int MAX_STEPS = 64;

	// Operation codes in the golden file
	localparam logic [31:0] OP_NONE = 32'h0;
	localparam logic [31:0] OP_READ = 32'h1;
	localparam logic [31:0] OP_WRITE = 32'h2;
	localparam logic [31:0] OP_END = 32'hf;

	logic clk;
	logic rst_n;

	// APB signals, index 0 and 1 are the two ports
	logic psel [2];
	logic penable [2];
	logic pwrite [2];
	logic [ADDR_W-1:0] paddr [2];
	logic [DATA_W-1:0] pwdata [2];
	logic [STRB_W-1:0] pstrb [2];
	logic [DATA_W-1:0] prdata [2];
	logic pready [2];
	logic pslverr [2];

	logic [31:0] golden [0:FIELDS*MAX_STEPS-1];
	int num_steps;
	int errors = 0;
	int checks = 0;
	int cycle_count = 0;
	int cycle_limit = 1000000;

	// ************************************************************
	// DUT
	// ************************************************************
	shared_scratchpad #(.DEPTH(DEPTH), .DATA_W(DATA_W)) DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.p0_psel    (psel[0]),
		.p0_penable (penable[0]),
		.p0_pwrite  (pwrite[0]),
		.p0_paddr   (paddr[0]),
		.p0_pwdata  (pwdata[0]),
		.p0_pstrb   (pstrb[0]),
		.p0_prdata  (prdata[0]),
		.p0_pready  (pready[0]),
		.p0_pslverr (pslverr[0]),
		.p1_psel    (psel[1]),
		.p1_penable (penable[1]),
		.p1_pwrite  (pwrite[1]),
		.p1_paddr   (paddr[1]),
		.p1_pwdata  (pwdata[1]),
		.p1_pstrb   (pstrb[1]),
		.p1_prdata  (prdata[1]),
		.p1_pready  (pready[1]),
		.p1_pslverr (pslverr[1])
	);

	// 10 ns clock
	always #5 clk = ~clk;

	// ************************************************************
	// Checking and end of run
	// ************************************************************
	task automatic check_value(input string name, input logic [DATA_W-1:0] actual,
		input logic [DATA_W-1:0] expected);
		checks++;
		if (actual !== expected)
		begin
			$display("ERROR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic end_run();
		$display("Run finished: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	endtask

	// Run length bound, set from the number of golden steps
	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("Timeout: the golden steps did not finish within %0d cycles", cycle_limit);
			errors++;
			end_run();
		end
	end

	// ************************************************************
	// One APB transfer on one port
	// ************************************************************

	// Entered and left 1 ns after a rising edge
	task automatic apb_transfer(input int p, input logic [31:0] op, input logic [31:0] addr,
		input logic [31:0] wdata, input logic [31:0] strb, input logic [31:0] expected);
		logic exp_err;
		logic got_err;
		logic [DATA_W-1:0] got_data;
		if (op != OP_NONE)
		begin
			// Word number past DEPTH must end in an error
			exp_err = (int'(addr[ADDR_W-1:0]) / STRB_W) >= DEPTH;
			// SETUP phase
			psel[p] = 1'b1;
			penable[p] = 1'b0;
			pwrite[p] = (op == OP_WRITE);
			paddr[p] = addr[ADDR_W-1:0];
			pwdata[p] = wdata[DATA_W-1:0];
			pstrb[p] = (op == OP_WRITE) ? strb[STRB_W-1:0] : '0;
			@(posedge clk);
			#1;
			// ACCESS phase, wait states until pready
			penable[p] = 1'b1;
			do
				@(negedge clk);
			while (!pready[p]);
			got_data = prdata[p];
			got_err = pslverr[p];
			check_value($sformatf("p%0d_pslverr", p), DATA_W'(got_err), DATA_W'(exp_err));
			if (op == OP_READ && !exp_err)
				check_value($sformatf("p%0d_prdata", p), got_data, expected);
			@(posedge clk);
			#1;
			psel[p] = 1'b0;
			penable[p] = 1'b0;
		end
	endtask

	// ************************************************************
	// Main sequence
	// ************************************************************
	initial
	begin
		int base;
		clk = 1'b0;
		rst_n = 1'b0;
		for (int p = 0; p < 2; p++)
		begin
			psel[p] = 1'b0;
			penable[p] = 1'b0;
			pwrite[p] = 1'b0;
			paddr[p] = '0;
			pwdata[p] = '0;
			pstrb[p] = '0;
		end
		$readmemh("dv/scratchpad_golden.txt", golden);
		num_steps = 0;
		while (num_steps < MAX_STEPS && golden[num_steps*FIELDS] !== OP_END)
			num_steps++;
		if (num_steps == MAX_STEPS)
		begin
			$display("The golden file has no end marker or could not be read");
			errors++;
			end_run();
		end
		else
		begin
			cycle_limit = CYCLES_PER_STEP * num_steps + RESET_CYCLES;

			repeat (RESET_CYCLES) @(posedge clk);
			#1;
			rst_n = 1'b1;

			// Both ports idle, no response may show up yet
			repeat (3)
			begin
				@(negedge clk);
				check_value("p0_pready", DATA_W'(pready[0]), '0);
				check_value("p0_pslverr", DATA_W'(pslverr[0]), '0);
				check_value("p1_pready", DATA_W'(pready[1]), '0);
				check_value("p1_pslverr", DATA_W'(pslverr[1]), '0);
			end
			@(posedge clk);
			#1;

			// Both ports start each step in the same cycle
			for (int s = 0; s < num_steps; s++)
			begin
				base = s * FIELDS;
				fork
					apb_transfer(0, golden[base], golden[base+1], golden[base+2],
						golden[base+3], golden[base+4]);
					apb_transfer(1, golden[base+5], golden[base+6], golden[base+7],
						golden[base+8], golden[base+9]);
				join
				@(posedge clk);
				#1;
			end
			end_run();
		end
	end

endmodule

//--- list.f
source/scratch_pkg.sv
source/mem_req_if.sv
source/apb_mem_port.sv
source/mem_arbiter.sv
source/mem_cell_1r1w.sv
source/shared_scratchpad.sv
dv/scratchpad_sva.sv
dv/tb_shared_scratchpad.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the scratchpad testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_shared_scratchpad

verilator --binary --timing --assert -f list.f --top-module "$TOP" -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
	exit 1
fi

if ! grep -q "TESTS PASSED" "$LOG"; then
	echo "Simulation ended without a result line"
	exit 1
fi

exit 0

//--- source/apb_mem_port.sv
`timescale 1ns/100ps

module apb_mem_port #(
	parameter int DEPTH  = 256,
	parameter int DATA_W = scratch_pkg::DATA_W
) (
	input  logic clk,
	input  logic rst_n,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [scratch_pkg::ADDR_W-1:0] paddr,
	input  logic [DATA_W-1:0] pwdata,
	input  logic [scratch_pkg::strb_w(DATA_W)-1:0] pstrb,
	output logic [DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr,
	mem_req_if.requester mem
);
	import scratch_pkg::*;

	// Byte offset bits below the word number
	localparam int OFF_W = $clog2(strb_w(DATA_W));

	typedef word_idx_t#(DEPTH)::t idx_t;

	typedef enum logic [1:0]
	{
		IDLE,
		WAIT_GNT,
		RESP
	} state_t;

	state_t state, state_nxt;

	logic access;
	logic in_range;
	logic [ADDR_W-1:0] word_num;
	idx_t word_idx;

	// ************************************************************
	// Address decode
	// ************************************************************

	// ACCESS phase of an APB transfer
	assign access = psel & penable;

	// Full word number, may reach past the memory
	assign word_num = paddr >> OFF_W;
	assign in_range = (word_num < DEPTH);
	assign word_idx = word_num[idx_w(DEPTH)-1:0];

	// ************************************************************
	// Transfer FSM
	// ************************************************************
	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE:
				// Grant in the first cycle skips the wait state
				if (access && in_range)
					state_nxt = mem.gnt ? RESP : WAIT_GNT;
			WAIT_GNT:
				if (mem.gnt)
					state_nxt = RESP;
			RESP:
				state_nxt = IDLE;
			default:
				state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// ************************************************************
	// Word request
	// ************************************************************

	// Rises with the first ACCESS cycle, held until granted
	assign mem.req = ((state == IDLE) & access & in_range) | (state == WAIT_GNT);

	// APB keeps these stable for the whole transfer
	assign mem.we    = pwrite;
	assign mem.idx   = word_idx;
	assign mem.strb  = pstrb;
	assign mem.wdata = pwdata;

	// ************************************************************
	// APB response
	// ************************************************************

	// Out of range ends at once with an error
	assign pslverr = (state == IDLE) & access & ~in_range;
	assign pready  = (state == RESP) | pslverr;

	// Read word arrives the cycle after the grant
	assign prdata = ((state == RESP) && !pwrite) ? mem.rdata : '0;

endmodule

//--- source/mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter #(
	parameter int DEPTH  = 256,
	parameter int DATA_W = scratch_pkg::DATA_W
) (
	input  logic clk,
	input  logic rst_n,
	mem_req_if.arbiter m0,
	mem_req_if.arbiter m1,
	output logic wenable,
	output logic [scratch_pkg::strb_w(DATA_W)-1:0] wstrb,
	output logic [scratch_pkg::idx_w(DEPTH)-1:0] windex,
	output logic [DATA_W-1:0] wdata,
	output logic renable,
	output logic [scratch_pkg::idx_w(DEPTH)-1:0] rindex,
	input  logic [DATA_W-1:0] rdata_synch
);
	import scratch_pkg::*;

	typedef word_idx_t#(DEPTH)::t idx_t;

	logic [NUM_PORTS-1:0] req_vec;
	logic [NUM_PORTS-1:0] gnt_vec;
	logic any_gnt;

	// High when port 1 won the last grant
	logic last_win;

	// Fields of the granted requester
	logic win_we;
	idx_t win_idx;
	logic [strb_w(DATA_W)-1:0] win_strb;
	logic [DATA_W-1:0] win_wdata;

	// ************************************************************
	// Round-robin grant
	// ************************************************************
	assign req_vec = {m1.req, m0.req};

	always_comb
	begin
		// Lone requester always wins
		// On a tie the port that lost last time goes first
		gnt_vec[0] = req_vec[0] & (~req_vec[1] | last_win);
		gnt_vec[1] = req_vec[1] & (~req_vec[0] | ~last_win);
	end

	assign any_gnt = |gnt_vec;
	assign m0.gnt  = gnt_vec[0];
	assign m1.gnt  = gnt_vec[1];

	// Starts as if port 1 had won, so port 0 leads after reset
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			last_win <= 1'b1;
		else if (any_gnt)
			last_win <= gnt_vec[1];
	end

	// ************************************************************
	// Winner mux toward the cell
	// ************************************************************
	always_comb
	begin
		if (gnt_vec[1])
		begin
			win_we    = m1.we;
			win_idx   = m1.idx;
			win_strb  = m1.strb;
			win_wdata = m1.wdata;
		end
		else
		begin
			win_we    = m0.we;
			win_idx   = m0.idx;
			win_strb  = m0.strb;
			win_wdata = m0.wdata;
		end
	end

	// One access per cycle, either a write or a read
	assign wenable = any_gnt & win_we;
	assign renable = any_gnt & ~win_we;
	assign windex  = win_idx;
	assign rindex  = win_idx;
	assign wstrb   = win_strb;
	assign wdata   = win_wdata;

	// ************************************************************
	// Read data return
	// ************************************************************

	// Shared to both, only the port in RESP samples it
	assign m0.rdata = rdata_synch;
	assign m1.rdata = rdata_synch;

endmodule

//--- source/mem_cell_1r1w.sv
`timescale 1ns/100ps

module mem_cell_1r1w #(
	parameter int DEPTH  = 256,
	parameter int DATA_W = scratch_pkg::DATA_W
) (
	input  logic clk,
	input  logic rst_n,
	input  logic wenable,
	input  logic [scratch_pkg::strb_w(DATA_W)-1:0] wstrb,
	input  logic [scratch_pkg::idx_w(DEPTH)-1:0] windex,
	input  logic [DATA_W-1:0] wdata,
	input  logic renable,
	input  logic [scratch_pkg::idx_w(DEPTH)-1:0] rindex,
	output logic [DATA_W-1:0] rdata_synch
);
	import scratch_pkg::*;

	// Storage array
	logic [DATA_W-1:0] mem [0:DEPTH-1];

	// One bit per data bit, set where the lane is written
	logic [DATA_W-1:0] wmask;

	// ************************************************************
	// Byte strobe expansion
	// ************************************************************
	always_comb
	begin
		for (int b = 0; b < DATA_W; b++)
			wmask[b] = wenable & wstrb[b / BYTE_W];
	end

	// ************************************************************
	// Write port
	// ************************************************************

	// Contents cleared by reset
	// Only masked bits take the new value
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < DEPTH; i++)
				mem[i] <= '0;
		end
		else if (wenable)
			mem[windex] <= (mem[windex] & ~wmask) | (wdata & wmask);
	end

	// ************************************************************
	// Registered read port
	// ************************************************************
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rdata_synch <= '0;
		else if (renable)
			rdata_synch <= mem[rindex];
	end

endmodule

//--- source/mem_req_if.sv
`timescale 1ns/100ps

interface mem_req_if #(
	parameter int DEPTH  = 256,
	parameter int DATA_W = scratch_pkg::DATA_W
);
	import scratch_pkg::*;

	// Request side, driven by the APB port
	logic req;
	logic we;
	word_idx_t#(DEPTH)::t idx;
	logic [strb_w(DATA_W)-1:0] strb;
	logic [DATA_W-1:0] wdata;

	// Response side, driven by the arbiter
	logic gnt;
	logic [DATA_W-1:0] rdata;

	// Port view
	modport requester (
		output req, we, idx, strb, wdata,
		input  gnt, rdata
	);

	// Arbiter view
	modport arbiter (
		input  req, we, idx, strb, wdata,
		output gnt, rdata
	);

endinterface

//--- source/scratch_pkg.sv
package scratch_pkg;

	// ************************************************************
	// Widths and counts shared by the scratchpad blocks
	// ************************************************************

	// Default data word width, overridden from the top level
	localparam int DATA_W = 32;

	// Bits per byte lane
	localparam int BYTE_W = 8;

	// Byte lanes for a given word width
	function automatic int strb_w(input int data_w);
		return data_w / BYTE_W;
	endfunction

	// Byte lanes at the default width
	localparam int STRB_W = strb_w(DATA_W);

	// APB byte address width
	localparam int ADDR_W = 12;

	// Requesters on the shared memory, arbiter is built for two
	localparam int NUM_PORTS = 2;

	// Index bits for a memory of depth entries, never below one
	function automatic int idx_w(input int depth);
		return (depth > 1) ? $clog2(depth) : 1;
	endfunction

	// ************************************************************
	// Word index type, sized by the DEPTH of the user
	// ************************************************************
	virtual class word_idx_t #(parameter int DEPTH = 256);
		typedef logic [idx_w(DEPTH)-1:0] t;
	endclass

endpackage

//--- source/shared_scratchpad.sv
`timescale 1ns/100ps

module shared_scratchpad #(
	parameter int DEPTH  = 256,
	parameter int DATA_W = scratch_pkg::DATA_W
) (
	input  logic clk,
	input  logic rst_n,

	// APB port 0
	input  logic p0_psel,
	input  logic p0_penable,
	input  logic p0_pwrite,
	input  logic [scratch_pkg::ADDR_W-1:0] p0_paddr,
	input  logic [DATA_W-1:0] p0_pwdata,
	input  logic [scratch_pkg::strb_w(DATA_W)-1:0] p0_pstrb,
	output logic [DATA_W-1:0] p0_prdata,
	output logic p0_pready,
	output logic p0_pslverr,

	// APB port 1
	input  logic p1_psel,
	input  logic p1_penable,
	input  logic p1_pwrite,
	input  logic [scratch_pkg::ADDR_W-1:0] p1_paddr,
	input  logic [DATA_W-1:0] p1_pwdata,
	input  logic [scratch_pkg::strb_w(DATA_W)-1:0] p1_pstrb,
	output logic [DATA_W-1:0] p1_prdata,
	output logic p1_pready,
	output logic p1_pslverr
);
	import scratch_pkg::*;

	// Arbiter to cell
	logic wenable;
	logic [strb_w(DATA_W)-1:0] wstrb;
	logic [idx_w(DEPTH)-1:0] windex;
	logic [DATA_W-1:0] wdata;
	logic renable;
	logic [idx_w(DEPTH)-1:0] rindex;
	logic [DATA_W-1:0] rdata_synch;

	// ************************************************************
	// Word request links, one per APB port
	// ************************************************************
	mem_req_if #(.DEPTH(DEPTH), .DATA_W(DATA_W)) m0_if ();
	mem_req_if #(.DEPTH(DEPTH), .DATA_W(DATA_W)) m1_if ();

	apb_mem_port #(.DEPTH(DEPTH), .DATA_W(DATA_W)) u_port0 (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (p0_psel),
		.penable (p0_penable),
		.pwrite  (p0_pwrite),
		.paddr   (p0_paddr),
		.pwdata  (p0_pwdata),
		.pstrb   (p0_pstrb),
		.prdata  (p0_prdata),
		.pready  (p0_pready),
		.pslverr (p0_pslverr),
		.mem     (m0_if.requester)
	);

	apb_mem_port #(.DEPTH(DEPTH), .DATA_W(DATA_W)) u_port1 (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (p1_psel),
		.penable (p1_penable),
		.pwrite  (p1_pwrite),
		.paddr   (p1_paddr),
		.pwdata  (p1_pwdata),
		.pstrb   (p1_pstrb),
		.prdata  (p1_prdata),
		.pready  (p1_pready),
		.pslverr (p1_pslverr),
		.mem     (m1_if.requester)
	);

	// ************************************************************
	// Arbitration and storage
	// ************************************************************
	mem_arbiter #(.DEPTH(DEPTH), .DATA_W(DATA_W)) u_arbiter (
		.clk         (clk),
		.rst_n       (rst_n),
		.m0          (m0_if.arbiter),
		.m1          (m1_if.arbiter),
		.wenable     (wenable),
		.wstrb       (wstrb),
		.windex      (windex),
		.wdata       (wdata),
		.renable     (renable),
		.rindex      (rindex),
		.rdata_synch (rdata_synch)
	);

	mem_cell_1r1w #(.DEPTH(DEPTH), .DATA_W(DATA_W)) u_cell (
		.clk         (clk),
		.rst_n       (rst_n),
		.wenable     (wenable),
		.wstrb       (wstrb),
		.windex      (windex),
		.wdata       (wdata),
		.renable     (renable),
		.rindex      (rindex),
		.rdata_synch (rdata_synch)
	);

endmodule
